// File: core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Boot address of the first instruction.
`define RESET_PC 32'h1c00_0000

// General purpose register count.
`define NUM_REGS 32

// Word address bits of each SRAM model.
`define SRAM_ADDR_WIDTH 16

`endif

// File: core_pkg.sv
package core_pkg;

    typedef enum logic [2:0] {
        stage_if,
        stage_id,
        stage_exe,
        stage_mem,
        stage_wb
    } stage_t;

    // One bit per ALU function.
    typedef logic [11:0] alu_op_t;

    localparam int alu_add  = 0;
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_and  = 4;
    localparam int alu_nor  = 5;
    localparam int alu_or   = 6;
    localparam int alu_xor  = 7;
    localparam int alu_sll  = 8;
    localparam int alu_srl  = 9;
    localparam int alu_sra  = 10;
    localparam int alu_lui  = 11;

    // ####################
    // Instruction formats.
    typedef struct packed {
        logic [5:0] op_31_26;
        logic [3:0] op_25_22;
        logic [1:0] op_21_20;
        logic [4:0] op_19_15;
        logic [4:0] rk;
        logic [4:0] rj;
        logic [4:0] rd;
    } inst_reg_view_t;

    typedef struct packed {
        logic [5:0]  op_31_26;
        logic [15:0] i16;      // si12 and ui5 sit in the low bits.
        logic [4:0]  rj;
        logic [4:0]  rd;
    } inst_imm_view_t;

    typedef union packed {
        inst_reg_view_t reg_view;
        inst_imm_view_t imm_view;
    } inst_word_t;

    typedef enum logic [2:0] {
        none,
        beq,
        bne,
        direct,
        jirl
    } branch_kind_t;

endpackage

// File: stage_fsm.sv
`timescale 1ns/100ps

module stage_fsm (
    input  logic             clk,
    input  logic             reset,
    input  logic             needs_exe,
    input  logic             needs_mem,
    input  logic             needs_wb,
    output core_pkg::stage_t stage,
    output logic             step_pc
);

    core_pkg::stage_t stage_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= core_pkg::stage_if;
        end else begin
            stage <= stage_next;
        end
    end

    always_comb begin
        stage_next = core_pkg::stage_if;
        case (stage)
            core_pkg::stage_if:  stage_next = core_pkg::stage_id;
            core_pkg::stage_id: begin
                if (needs_exe) stage_next = core_pkg::stage_exe; // Branches end here.
            end
            core_pkg::stage_exe: begin
                if (needs_mem) begin
                    stage_next = core_pkg::stage_mem;
                end else if (needs_wb) begin
                    stage_next = core_pkg::stage_wb;
                end
            end
            core_pkg::stage_mem: begin
                if (needs_wb) stage_next = core_pkg::stage_wb;  // Only loads.
            end
            default: stage_next = core_pkg::stage_if;
        endcase
    end

    // PC commits once per instruction.
    assign step_pc = (stage == core_pkg::stage_id);

endmodule

// File: pc_counter.sv
`timescale 1ns/100ps

`include "core_cfg.svh"

module pc_counter (
    input  logic        clk,
    input  logic        reset,
    input  logic        step_pc,
    input  logic        take_branch,
    input  logic [31:0] branch_target,
    output logic [31:0] pc
);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else if (step_pc) begin
            if (take_branch) begin
                pc <= branch_target;
            end else begin
                pc <= pc + 32'd4;  // Sequential fetch.
            end
        end
    end

endmodule

// File: inst_decoder.sv
`timescale 1ns/100ps

module inst_decoder (
    input  core_pkg::inst_word_t   inst,
    output core_pkg::alu_op_t      alu_op,
    output logic                   src1_is_pc,
    output logic                   src2_is_imm,
    output logic                   src2_is_rd,
    output logic                   res_from_mem,
    output logic                   reg_write,
    output logic                   mem_write,
    output logic [4:0]             dest,
    output logic [31:0]            imm,
    output logic [31:0]            branch_offset,
    output core_pkg::branch_kind_t branch_kind,
    output logic                   needs_exe,
    output logic                   needs_mem,
    output logic                   needs_wb
);

    logic [5:0]  op_hi;
    logic        is_3r;
    logic        is_shift;
    logic [11:0] si12;
    logic [15:0] si16;
    logic [19:0] si20;
    logic [25:0] si26;

    logic inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic inst_nor, inst_and, inst_or, inst_xor;
    logic inst_slli_w, inst_srli_w, inst_srai_w;
    logic inst_addi_w, inst_lu12i_w, inst_ld_w, inst_st_w;
    logic inst_jirl, inst_b, inst_bl, inst_beq, inst_bne;
    logic alu_class;

    // ####################
    // Opcode match.
    assign op_hi    = inst.reg_view.op_31_26;
    assign is_3r    = (op_hi == 6'h00) && (inst.reg_view.op_25_22 == 4'h0)
                    && (inst.reg_view.op_21_20 == 2'h1);
    assign is_shift = (op_hi == 6'h00) && (inst.reg_view.op_25_22 == 4'h1)
                    && (inst.reg_view.op_21_20 == 2'h0);

    assign inst_add_w   = is_3r && (inst.reg_view.op_19_15 == 5'h00);
    assign inst_sub_w   = is_3r && (inst.reg_view.op_19_15 == 5'h02);
    assign inst_slt     = is_3r && (inst.reg_view.op_19_15 == 5'h04);
    assign inst_sltu    = is_3r && (inst.reg_view.op_19_15 == 5'h05);
    assign inst_nor     = is_3r && (inst.reg_view.op_19_15 == 5'h08);
    assign inst_and     = is_3r && (inst.reg_view.op_19_15 == 5'h09);
    assign inst_or      = is_3r && (inst.reg_view.op_19_15 == 5'h0a);
    assign inst_xor     = is_3r && (inst.reg_view.op_19_15 == 5'h0b);
    assign inst_slli_w  = is_shift && (inst.reg_view.op_19_15 == 5'h01);
    assign inst_srli_w  = is_shift && (inst.reg_view.op_19_15 == 5'h09);
    assign inst_srai_w  = is_shift && (inst.reg_view.op_19_15 == 5'h11);
    assign inst_addi_w  = (op_hi == 6'h00) && (inst.reg_view.op_25_22 == 4'ha);
    assign inst_ld_w    = (op_hi == 6'h0a) && (inst.reg_view.op_25_22 == 4'h2);
    assign inst_st_w    = (op_hi == 6'h0a) && (inst.reg_view.op_25_22 == 4'h6);
    assign inst_lu12i_w = (op_hi == 6'h05) && !inst.imm_view.i16[15];
    assign inst_jirl    = (op_hi == 6'h13);
    assign inst_b       = (op_hi == 6'h14);
    assign inst_bl      = (op_hi == 6'h15);
    assign inst_beq     = (op_hi == 6'h16);
    assign inst_bne     = (op_hi == 6'h17);

    // ####################
    // Immediate fields.
    assign si12 = inst.imm_view.i16[11:0];
    assign si16 = inst.imm_view.i16;
    assign si20 = {inst.imm_view.i16[14:0], inst.imm_view.rj};
    assign si26 = {inst.imm_view.rj, inst.imm_view.rd, inst.imm_view.i16};

    always_comb begin
        if (inst_jirl || inst_bl) begin
            imm = 32'd4;                              // Link value is pc + 4.
        end else if (inst_lu12i_w) begin
            imm = {si20, 12'b0};
        end else begin
            imm = {{20{si12[11]}}, si12};
        end
    end

    assign branch_offset = (inst_b || inst_bl) ? {{4{si26[25]}}, si26, 2'b0}
                                               : {{14{si16[15]}}, si16, 2'b0};

    always_comb begin
        alu_op = '0;
        alu_op[core_pkg::alu_add]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w
                                   | inst_jirl | inst_bl;
        alu_op[core_pkg::alu_sub]  = inst_sub_w;
        alu_op[core_pkg::alu_slt]  = inst_slt;
        alu_op[core_pkg::alu_sltu] = inst_sltu;
        alu_op[core_pkg::alu_and]  = inst_and;
        alu_op[core_pkg::alu_nor]  = inst_nor;
        alu_op[core_pkg::alu_or]   = inst_or;
        alu_op[core_pkg::alu_xor]  = inst_xor;
        alu_op[core_pkg::alu_sll]  = inst_slli_w;
        alu_op[core_pkg::alu_srl]  = inst_srli_w;
        alu_op[core_pkg::alu_sra]  = inst_srai_w;
        alu_op[core_pkg::alu_lui]  = inst_lu12i_w;
    end

    always_comb begin
        branch_kind = core_pkg::none;
        if (inst_beq)             branch_kind = core_pkg::beq;
        else if (inst_bne)        branch_kind = core_pkg::bne;
        else if (inst_b || inst_bl) branch_kind = core_pkg::direct;
        else if (inst_jirl)       branch_kind = core_pkg::jirl;
    end

    assign alu_class = inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_nor | inst_and
                     | inst_or | inst_xor | inst_slli_w | inst_srli_w | inst_srai_w
                     | inst_addi_w | inst_lu12i_w;

    assign src1_is_pc   = inst_jirl | inst_bl | inst_b;
    assign src2_is_imm  = inst_slli_w | inst_srli_w | inst_srai_w | inst_addi_w | inst_ld_w
                        | inst_st_w | inst_lu12i_w | inst_jirl | inst_bl | inst_b;
    assign src2_is_rd   = inst_beq | inst_bne | inst_st_w;
    assign res_from_mem = inst_ld_w;
    assign reg_write    = alu_class | inst_ld_w | inst_bl | inst_jirl;
    assign mem_write    = inst_st_w;
    assign dest         = inst_bl ? 5'd1 : inst.reg_view.rd;

    // Unknown words set none of these and return to fetch.
    assign needs_exe = reg_write | inst_st_w;
    assign needs_mem = inst_ld_w | inst_st_w;
    assign needs_wb  = reg_write;

endmodule

// File: regfile.sv
`timescale 1ns/100ps

`include "core_cfg.svh"

module regfile (
    input  logic        clk,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    input  logic [4:0]  waddr,
    input  logic        we,
    input  logic [31:0] wdata,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    logic [31:0] regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is hardwired to zero on read.
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

endmodule

// File: alu.sv
`timescale 1ns/100ps

module alu (
    input  core_pkg::alu_op_t alu_op,
    input  logic [31:0]       src1,
    input  logic [31:0]       src2,
    output logic [31:0]       result
);

    logic [31:0] add_sub;
    logic [31:0] slt_res;
    logic [31:0] sltu_res;
    logic [31:0] sll_res;
    logic [31:0] srl_res;
    logic [31:0] sra_res;
    logic [4:0]  shamt;
    logic        use_sub;

    // Subtract shares the adder.
    assign use_sub = alu_op[core_pkg::alu_sub];
    assign add_sub = src1 + (use_sub ? ~src2 : src2) + {31'd0, use_sub};

    assign slt_res  = {31'd0, $signed(src1) < $signed(src2)};
    assign sltu_res = {31'd0, src1 < src2};

    assign shamt   = src2[4:0];
    assign sll_res = src1 << shamt;
    assign srl_res = src1 >> shamt;
    assign sra_res = $signed(src1) >>> shamt;  // Keeps the sign.

    // One-hot select.
    assign result = ({32{alu_op[core_pkg::alu_add] | use_sub}} & add_sub)
                  | ({32{alu_op[core_pkg::alu_slt]}}  & slt_res)
                  | ({32{alu_op[core_pkg::alu_sltu]}} & sltu_res)
                  | ({32{alu_op[core_pkg::alu_and]}}  & (src1 & src2))
                  | ({32{alu_op[core_pkg::alu_nor]}}  & ~(src1 | src2))
                  | ({32{alu_op[core_pkg::alu_or]}}   & (src1 | src2))
                  | ({32{alu_op[core_pkg::alu_xor]}}  & (src1 ^ src2))
                  | ({32{alu_op[core_pkg::alu_sll]}}  & sll_res)
                  | ({32{alu_op[core_pkg::alu_srl]}}  & srl_res)
                  | ({32{alu_op[core_pkg::alu_sra]}}  & sra_res)
                  | ({32{alu_op[core_pkg::alu_lui]}}  & src2);

endmodule

// File: la32_core_top.sv
`timescale 1ns/100ps

module la32_core_top (
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] inst_sram_addr,
    input  logic [31:0] inst_sram_rdata,
    output logic        data_sram_we,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  logic [31:0] data_sram_rdata,
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);

    core_pkg::stage_t       stage;
    core_pkg::inst_word_t   cur_inst;
    core_pkg::alu_op_t      alu_op;
    core_pkg::branch_kind_t branch_kind;

    logic        step_pc, take_branch, rj_eq_rd, rf_we;
    logic        src1_is_pc, src2_is_imm, src2_is_rd, res_from_mem;
    logic        reg_write, mem_write, needs_exe, needs_mem, needs_wb;
    logic [4:0]  dest;
    logic [31:0] pc, imm, branch_offset, branch_target;
    logic [31:0] rf_rdata1, rf_rdata2, alu_result;

    logic [31:0] inst_q;
    logic [31:0] inst_pc_q;
    logic [31:0] src1_q;
    logic [31:0] src2_q;
    logic [31:0] store_data_q;
    logic [31:0] result_q;

    assign inst_sram_addr = pc;

    // The fetched word is live during decode, latched for the later stages.
    assign cur_inst = (stage == core_pkg::stage_id) ? inst_sram_rdata : inst_q;

    stage_fsm u_stage_fsm (
        .clk(clk), .reset(reset),
        .needs_exe(needs_exe), .needs_mem(needs_mem), .needs_wb(needs_wb),
        .stage(stage), .step_pc(step_pc)
    );

    pc_counter u_pc_counter (
        .clk(clk), .reset(reset), .step_pc(step_pc), .take_branch(take_branch),
        .branch_target(branch_target), .pc(pc)
    );

    inst_decoder u_inst_decoder (
        .inst(cur_inst), .alu_op(alu_op), .src1_is_pc(src1_is_pc),
        .src2_is_imm(src2_is_imm), .src2_is_rd(src2_is_rd), .res_from_mem(res_from_mem),
        .reg_write(reg_write), .mem_write(mem_write), .dest(dest), .imm(imm),
        .branch_offset(branch_offset), .branch_kind(branch_kind),
        .needs_exe(needs_exe), .needs_mem(needs_mem), .needs_wb(needs_wb)
    );

    regfile u_regfile (
        .clk(clk),
        .raddr1(cur_inst.reg_view.rj),
        .raddr2(src2_is_rd ? cur_inst.reg_view.rd : cur_inst.reg_view.rk),
        .waddr(dest), .we(rf_we), .wdata(result_q),
        .rdata1(rf_rdata1), .rdata2(rf_rdata2)
    );

    alu u_alu (.alu_op(alu_op), .src1(src1_q), .src2(src2_q), .result(alu_result));

    // ####################
    // Branch resolve, in decode.
    assign rj_eq_rd    = (rf_rdata1 == rf_rdata2);
    assign take_branch = ((branch_kind == core_pkg::beq) && rj_eq_rd)
                       || ((branch_kind == core_pkg::bne) && !rj_eq_rd)
                       || (branch_kind == core_pkg::direct)
                       || (branch_kind == core_pkg::jirl);
    assign branch_target = ((branch_kind == core_pkg::jirl) ? rf_rdata1 : pc) + branch_offset;

    // ####################
    // Stage registers.
    always_ff @(posedge clk) begin
        case (stage)
            core_pkg::stage_id: begin
                inst_q       <= inst_sram_rdata;
                inst_pc_q    <= pc;
                src1_q       <= src1_is_pc ? pc : rf_rdata1;
                src2_q       <= src2_is_imm ? imm : rf_rdata2;
                store_data_q <= rf_rdata2;
            end
            core_pkg::stage_exe: result_q <= alu_result;
            core_pkg::stage_mem: begin
                if (res_from_mem) result_q <= data_sram_rdata;  // Load data replaces address.
            end
            default: ;
        endcase
    end

    assign data_sram_we    = mem_write && (stage == core_pkg::stage_exe);
    assign data_sram_addr  = alu_result;
    assign data_sram_wdata = store_data_q;

    assign rf_we = reg_write && (stage == core_pkg::stage_wb);

    assign debug_wb_pc       = inst_pc_q;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = dest;
    assign debug_wb_rf_wdata = result_q;

endmodule

// File: tb_checker.sv
`timescale 1ns/100ps

`include "core_cfg.svh"

module tb_checker (
    input logic        clk,
    input logic        reset,
    input logic [31:0] inst_sram_addr,
    input logic        data_sram_we,
    input logic [31:0] data_sram_addr,
    input logic [31:0] data_sram_wdata,
    input logic [31:0] debug_wb_pc,
    input logic [3:0]  debug_wb_rf_we,
    input logic [4:0]  debug_wb_rf_wnum,
    input logic [31:0] debug_wb_rf_wdata
);

    localparam int stuck_limit = 6;  // Fetch address unchanged this long means a self loop.

    logic [7:0]       exp_kind [$];
    logic [31:0]      exp_pc [$];
    logic [31:0]      exp_loc [$];
    logic [31:0]      exp_val [$];
    logic [8*24-1:0]  test_name;
    logic [31:0]      last_addr = '0;
    logic             active = 1'b0;
    logic             test_done = 1'b0;
    int               errors = 0;
    int               stuck = 0;
    int               pass_count = 0;
    int               fail_count = 0;

    task automatic start_test(input logic [8*24-1:0] name);
        exp_kind.delete();
        exp_pc.delete();
        exp_loc.delete();
        exp_val.delete();
        test_name = name;
        errors    = 0;
        test_done = 1'b0;
        active    = 1'b1;
    endtask

    task automatic add_expected(input logic [7:0] kind, input logic [31:0] pc,
                                input logic [31:0] loc, input logic [31:0] val);
        if (kind == "W" && loc >= `NUM_REGS) begin
            $display("Test %0s: expected write names register %0d, which does not exist",
                     test_name, loc);
            errors++;
        end
        exp_kind.push_back(kind);
        exp_pc.push_back(pc);
        exp_loc.push_back(loc);
        exp_val.push_back(val);
    endtask

    // ####################
    // Event compare.
    task automatic compare_event(input logic [7:0] kind, input logic [31:0] pc,
                                 input logic [31:0] loc, input logic [31:0] val);
        logic [7:0]  k;
        logic [31:0] p;
        logic [31:0] l;
        logic [31:0] v;
        if (exp_kind.size() == 0) begin
            $display("Test %0s: extra %s event at pc %h, nothing more was expected",
                     test_name, kind, pc);
            errors++;
        end else begin
            k = exp_kind.pop_front();
            p = exp_pc.pop_front();
            l = exp_loc.pop_front();
            v = exp_val.pop_front();
            if (k !== kind || p !== pc || l !== loc || v !== val) begin
                $write("Fail at %0t: %0s expected %s pc %h loc %h val %h", $time, test_name,
                       k, p, l, v);
                $display(", got %s pc %h loc %h val %h", kind, pc, loc, val);
                errors++;
            end
        end
    endtask

    task automatic finish_test();
        if (exp_kind.size() != 0) begin
            $display("Test %0s: %0d expected events never appeared", test_name, exp_kind.size());
            errors++;
        end
        if (errors == 0) begin
            pass_count++;
            $display("Test %0s: passed", test_name);
        end else begin
            fail_count++;
            $display("Test %0s: failed with %0d errors", test_name, errors);
        end
        active    = 1'b0;
        test_done = 1'b1;
    endtask

    task automatic report_counts();
        $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    endtask

    // Outputs are stable at the falling edge.
    always @(negedge clk) begin
        if (reset) begin
            stuck     = 0;
            last_addr = inst_sram_addr;
        end else if (active) begin
            if (debug_wb_rf_we != 4'h0) begin
                if (debug_wb_rf_we != 4'hf) begin
                    $display("Test %0s: write enable copies disagree at pc %h", test_name,
                             debug_wb_pc);
                    errors++;
                end
                compare_event("W", debug_wb_pc, {27'd0, debug_wb_rf_wnum}, debug_wb_rf_wdata);
            end
            if (data_sram_we) begin
                compare_event("S", debug_wb_pc, data_sram_addr, data_sram_wdata);
            end
            if (inst_sram_addr == last_addr) begin
                stuck++;
            end else begin
                stuck = 0;
            end
            last_addr = inst_sram_addr;
            if (stuck >= stuck_limit) finish_test();  // Branch to self reached.
        end
    end

endmodule

// File: tb_core.sv
`timescale 1ns/100ps

`include "core_cfg.svh"

module tb_core;

    localparam int mem_words = 1 << `SRAM_ADDR_WIDTH;

    logic        clk;
    logic        reset;
    logic [31:0] inst_sram_addr, inst_sram_rdata;
    logic        data_sram_we;
    logic [31:0] data_sram_addr, data_sram_wdata, data_sram_rdata;
    logic [31:0] debug_wb_pc, debug_wb_rf_wdata;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;

    logic [31:0] inst_mem [mem_words];
    logic [31:0] data_mem [mem_words];
    logic [31:0] inst_addr_s = '0;
    logic [31:0] data_addr_s = '0;
    logic [31:0] data_wdata_s = '0;
    logic        data_we_s = 1'b0;

    // Parsed vectors tagged with their test number.
    logic [8*24-1:0] names [$];
    int          ins_test [$];
    logic [31:0] ins_addr [$];
    logic [31:0] ins_word [$];
    int          dat_test [$];
    logic [31:0] dat_addr [$];
    logic [31:0] dat_word [$];
    int          exp_test [$];
    logic [7:0]  exp_kind [$];
    logic [31:0] exp_pc [$];
    logic [31:0] exp_loc [$];
    logic [31:0] exp_val [$];
    int          n_inst = 0;
    int          bad_vectors = 0;
    logic        vectors_loaded = 1'b0;

    la32_core_top i_la32_core_top (
        .clk(clk), .reset(reset),
        .inst_sram_addr(inst_sram_addr), .inst_sram_rdata(inst_sram_rdata),
        .data_sram_we(data_sram_we), .data_sram_addr(data_sram_addr),
        .data_sram_wdata(data_sram_wdata), .data_sram_rdata(data_sram_rdata),
        .debug_wb_pc(debug_wb_pc), .debug_wb_rf_we(debug_wb_rf_we),
        .debug_wb_rf_wnum(debug_wb_rf_wnum), .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

    tb_checker u_checker (
        .clk(clk), .reset(reset), .inst_sram_addr(inst_sram_addr),
        .data_sram_we(data_sram_we), .data_sram_addr(data_sram_addr),
        .data_sram_wdata(data_sram_wdata), .debug_wb_pc(debug_wb_pc),
        .debug_wb_rf_we(debug_wb_rf_we), .debug_wb_rf_wnum(debug_wb_rf_wnum),
        .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int word_index(input logic [31:0] addr);
        return int'(addr[`SRAM_ADDR_WIDTH+1:2]);
    endfunction

    // ####################
    // SRAM models with one cycle of latency.
    always @(negedge clk) begin
        inst_addr_s  = inst_sram_addr;
        data_addr_s  = data_sram_addr;
        data_wdata_s = data_sram_wdata;
        data_we_s    = data_sram_we;
    end

    always @(posedge clk) begin
        #0.5;
        if (data_we_s) data_mem[word_index(data_addr_s)] = data_wdata_s;
        inst_sram_rdata = inst_mem[word_index(inst_addr_s)];
        data_sram_rdata = data_mem[word_index(data_addr_s)];
    end

    task automatic read_vectors();
        int              fd;
        int              r;
        int              cur;
        logic            first;
        logic [8*24-1:0] tag;
        logic [8*24-1:0] name;
        logic [7:0]      kind;
        logic [31:0]     a, w, l;
        string           line;
        cur = -1;
        first = 1'b0;
        fd = $fopen("core_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open core_vectors.txt");
            bad_vectors++;
        end else begin
            while ($fscanf(fd, "%s", tag) == 1) begin
                if (tag == "#") begin
                    r = $fgets(line, fd);
                end else if (tag == "T") begin
                    r = $fscanf(fd, "%s", name);
                    names.push_back(name);
                    cur++;
                    first = 1'b1;
                end else if (tag == "I") begin
                    r = $fscanf(fd, "%h %h", a, w);
                    if (first && a != `RESET_PC) begin
                        $display("Test %0s does not start at the reset vector", names[cur]);
                        bad_vectors++;
                    end
                    first = 1'b0;
                    ins_test.push_back(cur);
                    ins_addr.push_back(a);
                    ins_word.push_back(w);
                    n_inst++;
                end else if (tag == "D") begin
                    r = $fscanf(fd, "%h %h", a, w);
                    dat_test.push_back(cur);
                    dat_addr.push_back(a);
                    dat_word.push_back(w);
                end else if (tag == "E") begin
                    r = $fscanf(fd, "%s %h %h %h", kind, a, l, w);
                    exp_test.push_back(cur);
                    exp_kind.push_back(kind);
                    exp_pc.push_back(a);
                    exp_loc.push_back(l);
                    exp_val.push_back(w);
                end else begin
                    $display("Unknown line tag in core_vectors.txt");
                    bad_vectors++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic load_test(input int t);
        for (int i = 0; i < mem_words; i++) begin
            inst_mem[i] = 32'hfc00_0000 | i;             // Undecodable filler.
            data_mem[i] = {~i[15:0], i[15:0]};
        end
        foreach (ins_test[i]) begin
            if (ins_test[i] == t) inst_mem[word_index(ins_addr[i])] = ins_word[i];
        end
        foreach (dat_test[i]) begin
            if (dat_test[i] == t) data_mem[word_index(dat_addr[i])] = dat_word[i];
        end
        u_checker.start_test(names[t]);
        foreach (exp_test[i]) begin
            if (exp_test[i] == t) begin
                u_checker.add_expected(exp_kind[i], exp_pc[i], exp_loc[i], exp_val[i]);
            end
        end
    endtask

    task automatic run_test(input int t);
        @(posedge clk);
        #0.5;
        reset = 1'b1;
        load_test(t);
        repeat (4) @(posedge clk);
        #0.5;
        reset = 1'b0;
        wait (u_checker.test_done);
    endtask

    // ####################
    // Watchdog.
    initial begin
        realtime limit;
        wait (vectors_loaded);
        limit = n_inst * 5 * 4 + 200;
        #limit;
        $display("Timeout: the core stopped producing trace events");
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        reset           = 1'b1;
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        read_vectors();
        vectors_loaded = 1'b1;
        for (int t = 0; t < names.size(); t++) run_test(t);
        u_checker.report_counts();
        if (bad_vectors == 0 && u_checker.fail_count == 0
            && u_checker.pass_count == names.size()) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: core_vectors.txt
# T name | I addr word | D addr word
# E kind(W writeback, S store) pc reg-or-addr value
T alu_ops
I 1c000000 02bffc04
I 1c000004 15000005
I 1c000008 029ffc06
I 1c00000c 00101887
I 1c000010 001118a8
I 1c000014 001218a9
I 1c000018 001298aa
I 1c00001c 001418ab
I 1c000020 0014988c
I 1c000024 001518ad
I 1c000028 0015948e
I 1c00002c 50000000
E W 1c000000 04 ffffffff
E W 1c000004 05 80000000
E W 1c000008 06 000007ff
E W 1c00000c 07 000007fe
E W 1c000010 08 7ffff801
E W 1c000014 09 00000001
E W 1c000018 0a 00000000
E W 1c00001c 0b 7ffff800
E W 1c000020 0c 000007ff
E W 1c000024 0d 800007ff
E W 1c000028 0e 7fffffff
T imm_shift
I 1c000000 15fdb964
I 1c000004 02a61c84
I 1c000008 00409085
I 1c00000c 0044a086
I 1c000010 0048a087
I 1c000014 02848c08
I 1c000018 00489109
I 1c00001c 50000000
E W 1c000000 04 fedcb000
E W 1c000004 04 fedca987
E W 1c000008 05 edca9870
E W 1c00000c 06 00fedca9
E W 1c000010 07 fffedca9
E W 1c000014 08 00000123
E W 1c000018 09 00000012
T memory
D 00000100 cafef00d
I 1c000000 02840004
I 1c000004 142468a5
I 1c000008 0299e0a5
I 1c00000c 29802085
I 1c000010 28802086
I 1c000014 28800087
I 1c000018 29bff087
I 1c00001c 28bff088
I 1c000020 50000000
E W 1c000000 04 00000100
E W 1c000004 05 12345000
E W 1c000008 05 12345678
E S 1c00000c 00000108 12345678
E W 1c000010 06 12345678
E W 1c000014 07 cafef00d
E S 1c000018 000000fc cafef00d
E W 1c00001c 08 cafef00d
T branches
I 1c000000 02801404
I 1c000004 02801405
I 1c000008 58000885
I 1c00000c 02800406
I 1c000010 5c000885
I 1c000014 02800806
I 1c000018 5c000886
I 1c00001c 02800c07
I 1c000020 58000886
I 1c000024 02801007
I 1c000028 50000000
E W 1c000000 04 00000005
E W 1c000004 05 00000005
E W 1c000014 06 00000002
E W 1c000024 07 00000004
T links_r0
I 1c000000 54001000
I 1c000004 02815400
I 1c000008 00100803
I 1c00000c 50000c00
I 1c000010 4c000022
I 1c000014 02802409
I 1c000018 50000000
E W 1c000000 01 1c000004
E W 1c000010 02 1c000014
E W 1c000004 00 00000055
E W 1c000008 03 1c000014

// File: sim.f
+incdir+.
core_pkg.sv
stage_fsm.sv
pc_counter.sv
inst_decoder.sv
regfile.sv
alu.sv
la32_core_top.sv
tb_checker.sv
tb_core.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_core
FILELIST  = sim.f
LOG       = sim.log
OBJ_DIR   = obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
